/* include/ch1_defs.svh */
`ifndef CH1_DEFS_SVH
`define CH1_DEFS_SVH

// Channel 1 field widths
`define CH1_FREQ_W 11
`define CH1_LEN_W 6
`define CH1_VOL_W 4
`define CH1_ADDR_W 3

// apu_clk cycles per frame step, 8 or more
`define CH1_FRAME_DIV 64

`endif

/* src/ch1_pkg.sv */
`include "ch1_defs.svh"

package ch1_pkg;

	typedef enum logic [`CH1_ADDR_W-1:0] {
		NR10 = 3'd0, // Sweep
		NR11 = 3'd1, // Duty and length load
		NR12 = 3'd2, // Envelope
		NR13 = 3'd3, // Frequency low
		NR14 = 3'd4  // Trigger, length enable, frequency high
	} ch1_reg_e;

	typedef enum logic [1:0] {
		DUTY_12 = 2'd0,
		DUTY_25 = 2'd1,
		DUTY_50 = 2'd2,
		DUTY_75 = 2'd3
	} ch1_duty_e;

	typedef enum logic [2:0] {
		STEP0, STEP1, STEP2, STEP3,
		STEP4, STEP5, STEP6, STEP7
	} ch1_frame_e;

endpackage

/* src/ch1_regs.sv */
`include "ch1_defs.svh"

module ch1_regs (
	input  logic                   apu_clk,
	input  logic                   rst_n,
	input  logic [`CH1_ADDR_W-1:0] addr,
	input  logic [7:0]             wdata,
	input  logic                   wr,
	input  logic                   rd,
	output logic [7:0]             rdata,
	output logic [2:0]             sweep_period,
	output logic                   sweep_neg,
	output logic [2:0]             sweep_shift,
	output ch1_pkg::ch1_duty_e     duty,
	output logic [`CH1_LEN_W-1:0]  len_load_val,
	output logic                   length_load,
	output logic [`CH1_VOL_W-1:0]  env_init,
	output logic                   env_up,
	output logic [2:0]             env_period,
	output logic [`CH1_FREQ_W-1:0] freq,
	output logic                   len_en,
	output logic                   trig,
	output logic                   dac_on
);
	import ch1_pkg::*;

	logic [6:0] nr10;
	logic [7:0] nr11;
	logic [7:0] nr12;
	logic [7:0] nr13;
	logic [2:0] nr14_freq;
	logic       nr14_len;
	ch1_reg_e   sel;

	assign sel = ch1_reg_e'(addr);

	always_ff @(posedge apu_clk or negedge rst_n) begin
		if (!rst_n) begin
			nr10      <= '0;
			nr11      <= '0;
			nr12      <= '0;
			nr13      <= '0;
			nr14_freq <= '0;
			nr14_len  <= 1'b0;
		end else if (wr) begin
			case (sel)
				NR10: nr10 <= wdata[6:0];
				NR11: nr11 <= wdata;
				NR12: nr12 <= wdata;
				NR13: nr13 <= wdata;
				NR14: begin
					nr14_freq <= wdata[2:0];
					nr14_len  <= wdata[6];
				end
				default: ; // Unused addresses
			endcase
		end
	end

	// Trigger bit is not stored, it only fires the pulse
	always_ff @(posedge apu_clk or negedge rst_n) begin
		if (!rst_n) begin
			trig        <= 1'b0;
			length_load <= 1'b0;
		end else begin
			trig        <= wr && (sel == NR14) && wdata[7];
			length_load <= wr && (sel == NR11);
		end
	end

	always_ff @(posedge apu_clk or negedge rst_n) begin
		if (!rst_n)
			rdata <= 8'h00;
		else if (rd) begin
			case (sel)
				NR10: rdata <= {1'b1, nr10};
				NR11: rdata <= {nr11[7:6], 6'h3f};
				NR12: rdata <= nr12;
				NR14: rdata <= {1'b1, nr14_len, 6'h3f};
				default: rdata <= 8'hff; // NR13 and unused read as ones
			endcase
		end
	end

	assign sweep_period = nr10[6:4];
	assign sweep_neg    = nr10[3];
	assign sweep_shift  = nr10[2:0];
	assign duty         = ch1_duty_e'(nr11[7:6]);
	assign len_load_val = nr11[`CH1_LEN_W-1:0];
	assign env_init     = nr12[7 -: `CH1_VOL_W];
	assign env_up       = nr12[3];
	assign env_period   = nr12[2:0];
	assign freq         = {nr14_freq, nr13};
	assign len_en       = nr14_len;
	assign dac_on       = |nr12[7:3]; // DAC off when volume and direction are all zero

endmodule

/* src/ch1_sweep.sv */
`include "ch1_defs.svh"

module ch1_sweep (
	input  logic                   apu_clk,
	input  logic                   rst_n,
	input  logic                   trig,
	input  logic                   sweep_tick,
	input  logic [2:0]             sweep_period,
	input  logic                   sweep_neg,
	input  logic [2:0]             sweep_shift,
	input  logic [`CH1_FREQ_W-1:0] freq,
	output logic [`CH1_FREQ_W-1:0] freq_cur,
	output logic                   sweep_kill
);

	logic [`CH1_FREQ_W-1:0] shadow;
	logic [2:0]             timer;
	logic [`CH1_FREQ_W:0]   next_freq;
	logic [`CH1_FREQ_W:0]   trig_freq;

	// Top bit of the result flags a frequency above 2047
	function automatic logic [`CH1_FREQ_W:0] sweep_calc(
		input logic [`CH1_FREQ_W-1:0] f,
		input logic [2:0]             shift,
		input logic                   neg
	);
		logic [`CH1_FREQ_W:0] delta;
		delta = {1'b0, f >> shift};
		if (neg)
			return {1'b0, f} - delta;
		return {1'b0, f} + delta;
	endfunction

	assign next_freq = sweep_calc(shadow, sweep_shift, sweep_neg);
	assign trig_freq = sweep_calc(freq, sweep_shift, sweep_neg);

	// Register frequency reaches the duty unit in the trigger cycle itself
	assign freq_cur = trig ? freq : shadow;

	always_ff @(posedge apu_clk or negedge rst_n) begin
		if (!rst_n) begin
			shadow     <= '0;
			timer      <= '0;
			sweep_kill <= 1'b0;
		end else begin
			sweep_kill <= 1'b0;
			if (trig) begin
				shadow <= freq;
				timer  <= sweep_period;
				if (sweep_shift != 3'd0 && trig_freq[`CH1_FREQ_W])
					sweep_kill <= 1'b1; // Immediate overflow check
			end else if (sweep_tick) begin
				if (timer > 3'd1)
					timer <= timer - 3'd1;
				else begin
					timer <= sweep_period;
					if (sweep_period != 3'd0) begin
						if (next_freq[`CH1_FREQ_W])
							sweep_kill <= 1'b1;
						else if (sweep_shift != 3'd0)
							shadow <= next_freq[`CH1_FREQ_W-1:0];
					end
				end
			end
		end
	end

endmodule

/* src/ch1_freq_duty.sv */
`include "ch1_defs.svh"

module ch1_freq_duty (
	input  logic                   apu_clk,
	input  logic                   rst_n,
	input  logic                   trig,
	input  logic [`CH1_FREQ_W-1:0] freq_cur,
	input  ch1_pkg::ch1_duty_e     duty,
	output logic                   wave
);
	import ch1_pkg::*;

	localparam logic [`CH1_FREQ_W:0] FREQ_SPAN = 1 << `CH1_FREQ_W;

	logic [`CH1_FREQ_W:0] cnt;
	logic [`CH1_FREQ_W:0] period;
	logic [2:0]           step;
	logic [7:0]           pattern;

	assign period = FREQ_SPAN - {1'b0, freq_cur}; // 1 to 2048 cycles per step

	// Each step lasts exactly period cycles
	always_ff @(posedge apu_clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			step <= 3'd0;
		end else if (trig) begin
			cnt  <= period;
			step <= 3'd0;
		end else if (cnt <= 1) begin
			cnt  <= period;
			step <= step + 3'd1;
		end else
			cnt <= cnt - 1'b1;
	end

	// Bit n of the pattern is the output during step n
	always_comb begin
		case (duty)
			DUTY_12: pattern = 8'b1000_0000;
			DUTY_25: pattern = 8'b1100_0000;
			DUTY_50: pattern = 8'b1111_0000;
			default: pattern = 8'b0011_1111; // 75 percent
		endcase
	end

	assign wave = pattern[step];

endmodule

/* src/ch1_envelope.sv */
`include "ch1_defs.svh"

module ch1_envelope (
	input  logic                  apu_clk,
	input  logic                  rst_n,
	input  logic                  trig,
	input  logic                  env_tick,
	input  logic [`CH1_VOL_W-1:0] env_init,
	input  logic                  env_up,
	input  logic [2:0]            env_period,
	output logic [`CH1_VOL_W-1:0] volume
);

	localparam logic [`CH1_VOL_W-1:0] VOL_MAX = '1;

	logic [2:0] timer;

	always_ff @(posedge apu_clk or negedge rst_n) begin
		if (!rst_n) begin
			volume <= '0;
			timer  <= '0;
		end else if (trig) begin
			volume <= env_init;
			timer  <= env_period;
		end else if (env_tick && env_period != 3'd0) begin
			if (timer > 3'd1)
				timer <= timer - 3'd1;
			else begin
				timer <= env_period;
				// Volume saturates at either end
				if (env_up && volume != VOL_MAX)
					volume <= volume + 1'b1;
				else if (!env_up && volume != '0)
					volume <= volume - 1'b1;
			end
		end
	end

endmodule

/* src/ch1_frame_seq.sv */
`include "ch1_defs.svh"

module ch1_frame_seq (
	input  logic                  apu_clk,
	input  logic                  rst_n,
	input  logic                  trig,
	input  logic                  length_load,
	input  logic [`CH1_LEN_W-1:0] len_load_val,
	input  logic                  len_en,
	input  logic                  sweep_kill,
	input  logic                  dac_on,
	output logic                  len_tick,
	output logic                  sweep_tick,
	output logic                  env_tick,
	output logic                  ch_on
);
	import ch1_pkg::*;

	localparam int DIV_W = $clog2(`CH1_FRAME_DIV);
	localparam logic [`CH1_LEN_W:0] LEN_FULL = 1 << `CH1_LEN_W;

	logic [DIV_W-1:0]    div_cnt;
	logic                div_wrap;
	ch1_frame_e          step;
	logic [`CH1_LEN_W:0] len_cnt;
	logic                len_expire;

	assign div_wrap = (div_cnt == DIV_W'(`CH1_FRAME_DIV - 1));

	always_ff @(posedge apu_clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt    <= '0;
			step       <= STEP0;
			len_tick   <= 1'b0;
			sweep_tick <= 1'b0;
			env_tick   <= 1'b0;
		end else begin
			len_tick   <= 1'b0;
			sweep_tick <= 1'b0;
			env_tick   <= 1'b0;
			if (div_wrap) begin
				div_cnt <= '0;
				step    <= ch1_frame_e'(step + 3'd1);
				case (step)
					STEP0, STEP4: len_tick <= 1'b1;
					STEP2, STEP6: begin
						len_tick   <= 1'b1;
						sweep_tick <= 1'b1;
					end
					STEP7: env_tick <= 1'b1;
					default: ;
				endcase
			end else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	assign len_expire = len_tick && len_en && (len_cnt == 1);

	always_ff @(posedge apu_clk or negedge rst_n) begin
		if (!rst_n)
			len_cnt <= '0;
		else if (length_load)
			len_cnt <= LEN_FULL - {1'b0, len_load_val};
		else if (trig) begin
			if (len_cnt == '0)
				len_cnt <= LEN_FULL; // Expired length restarts at full
		end else if (len_tick && len_en && len_cnt != '0)
			len_cnt <= len_cnt - 1'b1;
	end

	always_ff @(posedge apu_clk or negedge rst_n) begin
		if (!rst_n)
			ch_on <= 1'b0;
		else if (trig)
			ch_on <= dac_on;
		else if (sweep_kill || !dac_on || len_expire)
			ch_on <= 1'b0;
	end

endmodule

/* src/ch1_top.sv */
`include "ch1_defs.svh"

module ch1_top (
	input  logic                   apu_clk,
	input  logic                   rst_n,
	input  logic [`CH1_ADDR_W-1:0] addr,
	input  logic [7:0]             wdata,
	input  logic                   wr,
	input  logic                   rd,
	output logic [7:0]             rdata,
	output logic [`CH1_VOL_W-1:0]  level,
	output logic                   ch_on
);
	import ch1_pkg::*;

	logic [2:0]             sweep_period;
	logic                   sweep_neg;
	logic [2:0]             sweep_shift;
	ch1_duty_e              duty;
	logic [`CH1_LEN_W-1:0]  len_load_val;
	logic                   length_load;
	logic [`CH1_VOL_W-1:0]  env_init;
	logic                   env_up;
	logic [2:0]             env_period;
	logic [`CH1_FREQ_W-1:0] freq;
	logic [`CH1_FREQ_W-1:0] freq_cur;
	logic                   len_en;
	logic                   trig;
	logic                   dac_on;
	logic                   len_tick;
	logic                   sweep_tick;
	logic                   env_tick;
	logic                   sweep_kill;
	logic                   wave;
	logic [`CH1_VOL_W-1:0]  volume;

	ch1_regs regs_i (
		.apu_clk, .rst_n, .addr, .wdata, .wr, .rd, .rdata,
		.sweep_period, .sweep_neg, .sweep_shift, .duty,
		.len_load_val, .length_load, .env_init, .env_up, .env_period,
		.freq, .len_en, .trig, .dac_on
	);

	ch1_frame_seq frame_seq_i (
		.apu_clk, .rst_n, .trig, .length_load, .len_load_val, .len_en,
		.sweep_kill, .dac_on, .len_tick, .sweep_tick, .env_tick, .ch_on
	);

	ch1_sweep sweep_i (
		.apu_clk, .rst_n, .trig, .sweep_tick, .sweep_period, .sweep_neg,
		.sweep_shift, .freq, .freq_cur, .sweep_kill
	);

	ch1_freq_duty freq_duty_i (
		.apu_clk, .rst_n, .trig, .freq_cur, .duty, .wave
	);

	ch1_envelope envelope_i (
		.apu_clk, .rst_n, .trig, .env_tick, .env_init, .env_up, .env_period, .volume
	);

	assign level = {`CH1_VOL_W{wave & ch_on}} & volume; // Silent while the channel is off

endmodule

/* test/ch1_tb.sv */
`include "ch1_defs.svh"

module ch1_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import ch1_pkg::*;

	localparam int FRAME_DIV  = `CH1_FRAME_DIV;
	localparam int MAX_CYCLES = 20000; // Worst case of all tests is near 17500
	localparam logic [`CH1_VOL_W-1:0] VOL_MAX  = '1;
	localparam logic [`CH1_VOL_W-1:0] VOL_STEP = `CH1_VOL_W'(1);

	logic                   apu_clk;
	logic                   rst_n;
	logic [`CH1_ADDR_W-1:0] addr;
	logic [7:0]             wdata;
	logic                   wr;
	logic                   rd;
	logic [7:0]             rdata;
	logic [`CH1_VOL_W-1:0]  level;
	logic                   ch_on;

	integer seed = 32'he024_640f;
	logic   checking = 1'b0;
	int     cycle_cnt = 0;
	int     rdata_errs = 0;
	int     level_errs = 0;
	int     on_errs = 0;
	int     other_errs = 0;

	// Reference model state
	logic [7:0]            m_reg [0:4];
	logic [7:0]            m_rdata;
	logic                  m_trig;
	logic                  m_lload;
	logic [6:0]            m_len;
	logic                  m_on;
	logic [10:0]           m_shadow;
	logic [2:0]            m_sw_timer;
	logic                  m_kill;
	logic [11:0]           m_cnt;
	logic [2:0]            m_dstep;
	logic [`CH1_VOL_W-1:0] m_vol;
	logic [2:0]            m_env_timer;
	int                    m_div;
	logic [2:0]            m_fstep;
	logic                  m_len_tick;
	logic                  m_sw_tick;
	logic                  m_env_tick;

	ch1_top dut_i (
		.apu_clk, .rst_n, .addr, .wdata, .wr, .rd, .rdata, .level, .ch_on
	);

	initial begin
		apu_clk = 1'b0;
		forever #5 apu_clk = ~apu_clk;
	end

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic duty_high(input ch1_duty_e d, input logic [2:0] s);
		case (d)
			DUTY_12: return s == 3'd7;
			DUTY_25: return s >= 3'd6;
			DUTY_50: return s >= 3'd4;
			default: return s <= 3'd5;
		endcase
	endfunction

	function automatic logic [11:0] sweep_next(input logic [10:0] f, input logic [2:0] sh,
			input logic neg);
		logic [11:0] delta;
		delta = {1'b0, f >> sh};
		return neg ? {1'b0, f} - delta : {1'b0, f} + delta;
	endfunction

	function automatic logic [7:0] read_value(input logic [2:0] a);
		case (a)
			3'd0: return m_reg[0] | 8'h80;
			3'd1: return m_reg[1] | 8'h3f;
			3'd2: return m_reg[2];
			3'd4: return m_reg[4] | 8'hbf;
			default: return 8'hff;
		endcase
	endfunction

	function automatic logic [`CH1_VOL_W-1:0] expected_level();
		if (m_on && duty_high(ch1_duty_e'(m_reg[1][7:6]), m_dstep))
			return m_vol;
		return '0;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < 5; i++)
			m_reg[i] = 8'h00;
		m_rdata     = 8'h00;
		m_trig      = 1'b0;
		m_lload     = 1'b0;
		m_len       = 7'd0;
		m_on        = 1'b0;
		m_shadow    = 11'd0;
		m_sw_timer  = 3'd0;
		m_kill      = 1'b0;
		m_cnt       = 12'd0;
		m_dstep     = 3'd0;
		m_vol       = '0;
		m_env_timer = 3'd0;
		m_div       = 0;
		m_fstep     = 3'd0;
		m_len_tick  = 1'b0;
		m_sw_tick   = 1'b0;
		m_env_tick  = 1'b0;
	endtask

	// One apu_clk cycle, every part reads the state from before this edge
	task automatic model_step();
		logic        dac;
		logic [10:0] f_reg;
		logic [10:0] f_cur;
		logic [11:0] nf;
		logic [11:0] trig_nf;
		logic [11:0] per;
		logic        len_en;
		logic        expire;
		dac     = |m_reg[2][7:3];
		f_reg   = {m_reg[4][2:0], m_reg[3]};
		f_cur   = m_trig ? f_reg : m_shadow;
		per     = 12'd2048 - {1'b0, f_cur};
		len_en  = m_reg[4][6];
		expire  = m_len_tick && len_en && (m_len == 7'd1);
		nf      = sweep_next(m_shadow, m_reg[0][2:0], m_reg[0][3]);
		trig_nf = sweep_next(f_reg, m_reg[0][2:0], m_reg[0][3]);

		if (m_trig)
			m_on = dac;
		else if (m_kill || !dac || expire)
			m_on = 1'b0;

		if (m_lload)
			m_len = 7'd64 - {1'b0, m_reg[1][5:0]};
		else if (m_trig) begin
			if (m_len == 7'd0)
				m_len = 7'd64;
		end else if (m_len_tick && len_en && m_len != 7'd0)
			m_len = m_len - 7'd1;

		m_kill = 1'b0;
		if (m_trig) begin
			m_shadow   = f_reg;
			m_sw_timer = m_reg[0][6:4];
			m_kill     = (m_reg[0][2:0] != 3'd0) && trig_nf[11];
		end else if (m_sw_tick) begin
			if (m_sw_timer > 3'd1)
				m_sw_timer = m_sw_timer - 3'd1;
			else begin
				m_sw_timer = m_reg[0][6:4];
				if (m_reg[0][6:4] != 3'd0 && nf[11])
					m_kill = 1'b1; // Above 2047
				else if (m_reg[0][6:4] != 3'd0 && m_reg[0][2:0] != 3'd0)
					m_shadow = nf[10:0];
			end
		end

		if (m_trig) begin
			m_cnt   = per;
			m_dstep = 3'd0;
		end else if (m_cnt <= 12'd1) begin
			m_cnt   = per;
			m_dstep = m_dstep + 3'd1;
		end else
			m_cnt = m_cnt - 12'd1;

		if (m_trig) begin
			m_vol       = m_reg[2][7 -: `CH1_VOL_W];
			m_env_timer = m_reg[2][2:0];
		end else if (m_env_tick && m_reg[2][2:0] != 3'd0) begin
			if (m_env_timer > 3'd1)
				m_env_timer = m_env_timer - 3'd1;
			else begin
				m_env_timer = m_reg[2][2:0];
				if (m_reg[2][3] && m_vol != VOL_MAX)
					m_vol = m_vol + VOL_STEP;
				else if (!m_reg[2][3] && m_vol != '0)
					m_vol = m_vol - VOL_STEP;
			end
		end

		m_len_tick = 1'b0;
		m_sw_tick  = 1'b0;
		m_env_tick = 1'b0;
		if (m_div == FRAME_DIV - 1) begin
			m_div      = 0;
			m_len_tick = !m_fstep[0]; // Even steps
			m_sw_tick  = (m_fstep == 3'd2) || (m_fstep == 3'd6);
			m_env_tick = (m_fstep == 3'd7);
			m_fstep    = m_fstep + 3'd1;
		end else
			m_div = m_div + 1;

		if (rd)
			m_rdata = read_value(addr);
		m_trig  = wr && (addr == 3'd4) && wdata[7];
		m_lload = wr && (addr == 3'd1);
		if (wr && addr <= 3'd4)
			m_reg[addr] = wdata;
	endtask

	always @(posedge apu_clk) begin
		if (!rst_n)
			model_reset();
		else
			model_step();
	end

	task automatic check_rdata(input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			rdata_errs = rdata_errs + 1;
			$display("FAILED at %0t: rdata expected %02h, got %02h", $time, exp, act);
		end
	endtask

	task automatic check_level(input logic [`CH1_VOL_W-1:0] exp,
			input logic [`CH1_VOL_W-1:0] act);
		if (act !== exp) begin
			level_errs = level_errs + 1;
			$display("FAILED at %0t: level expected %0d, got %0d", $time, exp, act);
		end
	endtask

	task automatic check_on(input logic exp, input logic act);
		if (act !== exp) begin
			on_errs = on_errs + 1;
			$display("FAILED at %0t: ch_on expected %b, got %b", $time, exp, act);
		end
	endtask

	task automatic report_problem(input string msg);
		other_errs = other_errs + 1;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	// Outputs are settled half a cycle after the rising edge
	always @(negedge apu_clk) begin
		if (checking) begin
			check_rdata(m_rdata, rdata);
			check_level(expected_level(), level);
			check_on(m_on, ch_on);
		end
	end

	task automatic report_and_finish();
		$display("Errors: rdata %0d, level %0d, ch_on %0d, other %0d",
			rdata_errs, level_errs, on_errs, other_errs);
		if (rdata_errs + level_errs + on_errs + other_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	always @(posedge apu_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES) begin
			report_problem("run did not finish within the cycle limit");
			report_and_finish();
		end
	end

	task automatic idle(input int n);
		repeat (n) @(negedge apu_clk);
	endtask

	task automatic bus_write(input logic [2:0] a, input logic [7:0] d);
		@(negedge apu_clk);
		addr  = a;
		wdata = d;
		wr    = 1'b1;
		@(negedge apu_clk);
		wr = 1'b0;
	endtask

	task automatic bus_read(input logic [2:0] a);
		@(negedge apu_clk);
		addr = a;
		rd   = 1'b1;
		@(negedge apu_clk);
		rd = 1'b0;
	endtask

	// Sweep, duty, envelope, then frequency and the trigger write
	task automatic start_voice(input logic [7:0] nr10, input logic [7:0] nr11,
			input logic [7:0] nr12, input logic [10:0] f, input logic len_en);
		bus_write(3'd0, nr10);
		bus_write(3'd1, nr11);
		bus_write(3'd2, nr12);
		bus_write(3'd3, f[7:0]);
		bus_write(3'd4, {1'b1, len_en, 3'b000, f[10:8]});
	endtask

	task automatic wait_off(input int limit, output logic fell);
		int n;
		n = 0;
		while (ch_on === 1'b1 && n < limit) begin
			@(negedge apu_clk);
			n = n + 1;
		end
		fell = (ch_on !== 1'b1);
	endtask

	initial begin
		int unsigned a;
		logic [7:0]  d;
		logic [10:0] f;
		logic [5:0]  len;
		logic [3:0]  vol;
		logic [2:0]  per;
		logic [2:0]  sh;
		logic        up;
		logic        fell;
		addr  = '0;
		wdata = 8'h00;
		wr    = 1'b0;
		rd    = 1'b0;
		rst_n = 1'b0;
		repeat (2) @(negedge apu_clk);
		rst_n    = 1'b1;
		checking = 1'b1;

		// Register writes and masked readback
		for (int i = 0; i < 40; i++) begin
			a = rand_below(8);
			d = 8'(rand_below(256));
			bus_write(a[2:0], d);
			bus_read(a[2:0]);
		end

		// Duty patterns over two waveform periods
		for (int i = 0; i < 2; i++) begin
			f = 11'(1901 + rand_below(147));
			d = 8'(rand_below(4));
			start_voice(8'h00, {d[1:0], 6'h00}, 8'hf0, f, 1'b0);
			idle(16 * (2048 - int'(f)) + 4);
		end

		// Length counter with and without enable
		len = 6'(48 + rand_below(16));
		start_voice(8'h00, {2'b10, len}, 8'hf0, 11'd2000, 1'b1);
		wait_off((66 - int'(len)) * 2 * FRAME_DIV, fell);
		if (!fell)
			report_problem("ch_on stayed high after the length ran out");
		start_voice(8'h00, {2'b10, len}, 8'hf0, 11'd2000, 1'b0);
		idle((66 - int'(len)) * 2 * FRAME_DIV);
		if (ch_on !== 1'b1)
			report_problem("ch_on fell while length enable was clear");

		// Envelope, start volume close to the end it moves toward
		for (int i = 0; i < 2; i++) begin
			up  = rand_below(2) == 1;
			per = 3'(1 + rand_below(2));
			vol = up ? 4'(13 + rand_below(3)) : 4'(1 + rand_below(3));
			start_voice(8'h00, 8'h80, {vol, up, per}, 11'd2000, 1'b0);
			idle(4 * 8 * FRAME_DIV);
		end

		// Sweep upward until overflow or the window ends
		for (int i = 0; i < 3; i++) begin
			sh = 3'(1 + rand_below(7));
			f  = 11'(1700 + rand_below(300));
			start_voice({1'b0, 3'd1, 1'b0, sh}, 8'h80, 8'hf0, f, 1'b0);
			idle(2); // Trigger reaches ch_on
			wait_off(5 * 4 * FRAME_DIV, fell);
		end

		// DAC off
		start_voice(8'h00, 8'h80, 8'hf0, 11'd1800, 1'b0);
		idle(4);
		if (ch_on !== 1'b1)
			report_problem("ch_on did not rise after the trigger");
		bus_write(3'd2, {5'b00000, 3'(rand_below(8))});
		wait_off(4, fell);
		if (!fell)
			report_problem("ch_on stayed high after the DAC was switched off");
		idle(8);
		report_and_finish();
	end

endmodule

/* vlog.f */
+incdir+include
src/ch1_pkg.sv
src/ch1_regs.sv
src/ch1_sweep.sv
src/ch1_freq_duty.sv
src/ch1_envelope.sv
src/ch1_frame_seq.sv
src/ch1_top.sv
test/ch1_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the channel 1 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module ch1_tb -o ch1_sim
./obj_dir/ch1_sim > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "Simulation reported errors"
	exit 1
fi
echo "Simulation finished without errors"
